// ==== tb/fetch_golden.txt ====
// records in hex, a type word then its fields, type 0 ends the data
// 6 thread boot | 5 thread halt_cycles | 1 addr word | 2 fault_addr
// 3 thread pc word fault taken target | 4 thread after_pc event addr
// events: 1 mispredict, 2 exception, 3 eret, 4 commit pc reload
6 0 00000100
6 1 00000200
5 1 40
// memory image
1 00000100 00100093
1 00000104 00200113
1 00000108 0180006f
1 00000110 00300193
1 00000114 ff5ff06f
1 00000118 00400213
1 00000120 00000463
1 00000124 fe0096e3
1 00000140 00500293
1 00000200 00600313
1 00000204 00700393
1 00000240 00800413
1 00000264 01c0006f
1 00000280 00900493
1 00000284 00a00513
1 00000300 00b00593
1 00000304 00c00613
2 00000114
// thread 0 stream
3 0 00000100 00100093 0 0 00000104
3 0 00000104 00200113 0 0 00000108
3 0 00000108 0180006f 0 1 00000120
3 0 00000120 00000463 0 0 00000124
3 0 00000124 fe0096e3 0 1 00000110
3 0 00000110 00300193 0 0 00000114
3 0 00000114 ff5ff06f 1 0 00000118
3 0 00000118 00400213 0 0 0000011c
3 0 00000140 00500293 0 0 00000144
3 0 00000300 00b00593 0 0 00000304
3 0 00000304 00c00613 0 0 00000308
// thread 1 stream
3 1 00000200 00600313 0 0 00000204
3 1 00000204 00700393 0 0 00000208
3 1 00000240 00800413 0 0 00000244
3 1 00000264 01c0006f 0 1 00000280
3 1 00000280 00900493 0 0 00000284
3 1 00000284 00a00513 0 0 00000288
// redirects
4 0 00000118 1 00000140
4 0 00000140 2 00000300
4 1 00000204 3 00000240
4 1 00000240 4 00000260
0

// ==== sources.f ====
design/fetch_pkg.sv
design/static_branch_scan.sv
design/thread_scheduler.sv
design/thread_pc.sv
design/fetch_response.sv
design/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_fetch_frontend
FILELIST  := sources.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_fetch_frontend.sv ====
// Testbench for the multithreaded fetch front end
// Plays a golden file with a memory image, fault addresses, back-end
// redirects and one expected entry stream per thread. The cache model
// refuses requests at random and answers accepted ones a cycle later
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;
  import fetch_pkg::*;

  localparam int NumThreads = 2;
  localparam int AddrWidth  = 32;
  localparam int MaxEntries = 32;
  localparam int MaxCmds    = 8;
  localparam int GoldenSize = 256;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 req_o;
  logic [AddrWidth-1:0]                 vaddr_o;
  logic                                 ready_i;
  logic                                 valid_i;
  logic [31:0]                          data_i;
  logic                                 fault_i;
  logic                                 fetch_valid_o;
  logic                                 fetch_ready_i;
  logic [AddrWidth-1:0]                 fetch_pc_o;
  instr_u                               fetch_instr_o;
  logic [0:0]                           fetch_thread_o;
  logic                                 fetch_fault_o;
  logic                                 fetch_taken_o;
  logic [AddrWidth-1:0]                 fetch_target_o;
  logic                                 resolve_valid_i;
  logic [0:0]                           resolve_thread_i;
  logic [AddrWidth-1:0]                 resolve_target_i;
  logic                                 ex_valid_i;
  logic                                 eret_i;
  logic                                 set_pc_commit_i;
  logic [0:0]                           commit_thread_i;
  logic [AddrWidth-1:0]                 trap_vector_base_i;
  logic [AddrWidth-1:0]                 epc_i;
  logic [AddrWidth-1:0]                 pc_commit_i;
  logic [NumThreads-1:0][AddrWidth-1:0] boot_addr_i;
  logic [NumThreads-1:0]                halt_i;

  // golden data
  logic [31:0]          golden [0:GoldenSize-1];
  logic [31:0]          image [logic [31:0]];
  bit                   fault_addr [logic [31:0]];
  logic [AddrWidth-1:0] exp_pc [NumThreads][MaxEntries];
  instr_u               exp_word [NumThreads][MaxEntries];
  logic                 exp_fault [NumThreads][MaxEntries];
  logic                 exp_taken [NumThreads][MaxEntries];
  logic [AddrWidth-1:0] exp_target [NumThreads][MaxEntries];
  int                   exp_count [NumThreads];
  int                   exp_ptr [NumThreads];
  int                   halt_until [NumThreads];
  logic [AddrWidth-1:0] boot [NumThreads];
  int                   cmd_thread [MaxCmds];
  logic [31:0]          cmd_pc [MaxCmds];
  int                   cmd_event [MaxCmds];
  logic [31:0]          cmd_addr [MaxCmds];
  bit                   cmd_used [MaxCmds];
  int                   cmd_count;
  int                   cmd_fire;

  logic        resp_pending;
  logic [31:0] resp_addr;
  int          cycle;
  int          seed;
  bit          loaded;

  fetch_frontend #(
    .NumThreads (NumThreads),
    .AddrWidth  (AddrWidth)
  ) u_dut (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_addr(input string name, input logic [AddrWidth-1:0] exp,
                            input logic [AddrWidth-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_instr(input string name, input instr_u exp, input instr_u act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp.raw, act.raw));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // unlisted addresses read an addi whose bits depend on the whole address
  function automatic logic [31:0] word_at(input logic [31:0] a);
    if (image.exists(a)) begin
      return image[a];
    end else begin
      return {a[24:0] ^ a[31:7], 7'h13};
    end
  endfunction

  task automatic load_golden();
    int i;
    int t;
    int n;
    for (i = 0; i < GoldenSize; i++) begin
      golden[i] = '0;
    end
    $readmemh("tb/fetch_golden.txt", golden);
    if (golden[0] == 0) begin
      abort_run("golden file tb/fetch_golden.txt is missing or empty");
    end
    i = 0;
    while (i < GoldenSize - 8 && golden[i] != 0) begin
      t = int'(golden[i+1]);
      if (golden[i] > 2 && t >= NumThreads) begin
        abort_run($sformatf("golden record at word %0d names thread %0d", i, t));
      end
      case (golden[i])
        32'd1: begin
          image[golden[i+1]] = golden[i+2];
          i += 3;
        end
        32'd2: begin
          fault_addr[golden[i+1]] = 1'b1;
          i += 2;
        end
        32'd3: begin
          n = exp_count[t];
          if (n >= MaxEntries) begin
            abort_run("golden file holds too many entries for one thread");
          end
          exp_pc[t][n]     = golden[i+2];
          exp_word[t][n]   = golden[i+3];
          exp_fault[t][n]  = golden[i+4][0];
          exp_taken[t][n]  = golden[i+5][0];
          exp_target[t][n] = golden[i+6];
          exp_count[t]     = n + 1;
          i += 7;
        end
        32'd4: begin
          if (cmd_count >= MaxCmds) begin
            abort_run("golden file holds too many redirect commands");
          end
          cmd_thread[cmd_count] = t;
          cmd_pc[cmd_count]     = golden[i+2];
          cmd_event[cmd_count]  = int'(golden[i+3]);
          cmd_addr[cmd_count]   = golden[i+4];
          cmd_count++;
          i += 5;
        end
        32'd5: begin
          halt_until[t] = int'(golden[i+2]);
          i += 3;
        end
        32'd6: begin
          boot[t] = golden[i+2];
          i += 3;
        end
        default: abort_run($sformatf("unknown golden record type %0d", golden[i]));
      endcase
    end
  endtask

  function automatic bit streams_done();
    bit done;
    done = 1'b1;
    for (int t = 0; t < NumThreads; t++) begin
      if (exp_ptr[t] < exp_count[t]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic clear_back_end();
    resolve_valid_i = 1'b0;
    ex_valid_i      = 1'b0;
    eret_i          = 1'b0;
    set_pc_commit_i = 1'b0;
  endtask

  // events: 1 mispredict, 2 exception, 3 eret, 4 commit pc reload
  task automatic apply_command(input int c);
    resolve_thread_i = 1'(cmd_thread[c]);
    commit_thread_i  = 1'(cmd_thread[c]);
    case (cmd_event[c])
      1: begin
        resolve_valid_i  = 1'b1;
        resolve_target_i = cmd_addr[c];
      end
      2: begin
        ex_valid_i         = 1'b1;
        trap_vector_base_i = cmd_addr[c];
      end
      3: begin
        eret_i = 1'b1;
        epc_i  = cmd_addr[c];
      end
      4: begin
        set_pc_commit_i = 1'b1;
        pc_commit_i     = cmd_addr[c];
      end
      default: abort_run($sformatf("unknown redirect event %0d", cmd_event[c]));
    endcase
  endtask

  // ----------------------------------------
  // per-cycle drive and observe
  // ----------------------------------------
  task automatic drive_cycle();
    cycle++;
    valid_i      = resp_pending;
    data_i       = resp_pending ? word_at(resp_addr) : 32'h0;
    fault_i      = resp_pending && fault_addr.exists(resp_addr);
    resp_pending = 1'b0;
    ready_i      = (($random(seed) & 3) != 0);
    for (int t = 0; t < NumThreads; t++) begin
      halt_i[t] = (cycle < halt_until[t]);
    end
    clear_back_end();
    // decode stalls while the redirect pulse flushes older entries
    if (cmd_fire >= 0) begin
      apply_command(cmd_fire);
      fetch_ready_i = 1'b0;
      cmd_fire      = -1;
    end else begin
      fetch_ready_i = (($random(seed) & 7) != 0);
    end
  endtask

  task automatic check_entry();
    int t;
    int n;
    t = int'(fetch_thread_o);
    if (halt_i[t]) begin
      abort_run($sformatf("thread %0d emitted pc %h while halted", t, fetch_pc_o));
    end
    // a thread past its stream keeps fetching, those entries are ignored
    if (exp_ptr[t] < exp_count[t]) begin
      n = exp_ptr[t];
      check_addr("fetch_pc_o", exp_pc[t][n], fetch_pc_o);
      check_instr("fetch_instr_o", exp_word[t][n], fetch_instr_o);
      check_bit("fetch_fault_o", exp_fault[t][n], fetch_fault_o);
      check_bit("fetch_taken_o", exp_taken[t][n], fetch_taken_o);
      check_addr("fetch_target_o", exp_target[t][n], fetch_target_o);
      exp_ptr[t] = n + 1;
      for (int c = 0; c < cmd_count; c++) begin
        if (!cmd_used[c] && cmd_thread[c] == t && cmd_pc[c] == fetch_pc_o) begin
          cmd_used[c] = 1'b1;
          cmd_fire    = c;
          break;
        end
      end
    end
  endtask

  task automatic observe_cycle();
    if (req_o && ready_i) begin
      resp_pending = 1'b1;
      resp_addr    = vaddr_o;
    end
    if (fetch_valid_o && fetch_ready_i) begin
      check_entry();
    end
  endtask

  initial begin : main
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    ready_i            = 1'b0;
    valid_i            = 1'b0;
    data_i             = '0;
    fault_i            = 1'b0;
    fetch_ready_i      = 1'b0;
    resolve_thread_i   = '0;
    resolve_target_i   = '0;
    commit_thread_i    = '0;
    trap_vector_base_i = '0;
    epc_i              = '0;
    pc_commit_i        = '0;
    boot_addr_i        = '0;
    halt_i             = '0;
    clear_back_end();
    seed         = 84;
    resp_pending = 1'b0;
    resp_addr    = '0;
    cmd_fire     = -1;
    cmd_count    = 0;
    cycle        = 0;
    for (int t = 0; t < NumThreads; t++) begin
      exp_count[t]  = 0;
      exp_ptr[t]    = 0;
      halt_until[t] = 0;
      boot[t]       = '0;
    end
    load_golden();
    for (int t = 0; t < NumThreads; t++) begin
      boot_addr_i[t] = boot[t];
      halt_i[t]      = (halt_until[t] > 0);
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    while (!streams_done()) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      @(negedge clk_i);
      observe_cycle();
    end
    $display("NO ERRORS");
    $finish;
  end

  // 40 cycles per expected entry on top of reset and halt time
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 8;
    for (int t = 0; t < NumThreads; t++) begin
      limit += halt_until[t] + 40 * exp_count[t];
    end
    repeat (limit) @(posedge clk_i);
    abort_run($sformatf("timeout after %0d cycles with expected entries still missing",
                        limit));
  end

endmodule

`default_nettype wire

// ==== design/fetch_frontend.sv ====
// Multithreaded fetch front end, top level
// One single-word cache request per cycle from a round-robin thread
// choice, with per-thread program counters and a predecoding response
// stage that feeds decode through valid/ready
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
  parameter int  NumThreads = 2,
  parameter int  AddrWidth  = fetch_pkg::ADDR_W_DEFAULT,
  localparam int TidW       = (NumThreads > 1) ? $clog2(NumThreads) : 1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // instruction cache
  output logic                                 req_o,
  output logic [AddrWidth-1:0]                 vaddr_o,
  input  logic                                 ready_i,
  input  logic                                 valid_i,
  input  logic [31:0]                          data_i,
  input  logic                                 fault_i,
  // decode
  output logic                                 fetch_valid_o,
  input  logic                                 fetch_ready_i,
  output logic [AddrWidth-1:0]                 fetch_pc_o,
  output fetch_pkg::instr_u                    fetch_instr_o,
  output logic [TidW-1:0]                      fetch_thread_o,
  output logic                                 fetch_fault_o,
  output logic                                 fetch_taken_o,
  output logic [AddrWidth-1:0]                 fetch_target_o,
  // back end
  input  logic                                 resolve_valid_i,
  input  logic [TidW-1:0]                      resolve_thread_i,
  input  logic [AddrWidth-1:0]                 resolve_target_i,
  input  logic                                 ex_valid_i,
  input  logic                                 eret_i,
  input  logic                                 set_pc_commit_i,
  input  logic [TidW-1:0]                      commit_thread_i,
  input  logic [AddrWidth-1:0]                 trap_vector_base_i,
  input  logic [AddrWidth-1:0]                 epc_i,
  input  logic [AddrWidth-1:0]                 pc_commit_i,
  input  logic [NumThreads-1:0][AddrWidth-1:0] boot_addr_i,
  input  logic [NumThreads-1:0]                halt_i
);

  logic                                 can_issue;
  logic [TidW-1:0]                      cur_thread;
  logic [NumThreads-1:0]                advance;
  logic [NumThreads-1:0]                predict;
  logic [AddrWidth-1:0]                 predict_target;
  logic [NumThreads-1:0]                flush;
  logic [NumThreads-1:0][AddrWidth-1:0] pc;

  thread_scheduler #(
    .NumThreads (NumThreads)
  ) u_scheduler (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .halt_i         (halt_i),
    .can_issue_i    (can_issue),
    .icache_ready_i (ready_i),
    .req_o          (req_o),
    .cur_thread_o   (cur_thread),
    .advance_o      (advance)
  );

  for (genvar g = 0; g < NumThreads; g++) begin : gen_thread_pc
    thread_pc #(
      .NumThreads (NumThreads),
      .AddrWidth  (AddrWidth),
      .ThreadId   (g)
    ) u_thread_pc (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .boot_addr_i        (boot_addr_i[g]),
      .advance_i          (advance[g]),
      .predict_i          (predict[g]),
      .predict_target_i   (predict_target),
      .resolve_valid_i    (resolve_valid_i),
      .resolve_thread_i   (resolve_thread_i),
      .resolve_target_i   (resolve_target_i),
      .ex_valid_i         (ex_valid_i),
      .eret_i             (eret_i),
      .set_pc_commit_i    (set_pc_commit_i),
      .commit_thread_i    (commit_thread_i),
      .trap_vector_base_i (trap_vector_base_i),
      .epc_i              (epc_i),
      .pc_commit_i        (pc_commit_i),
      .pc_o               (pc[g]),
      .flush_o            (flush[g])
    );
  end

  fetch_response #(
    .NumThreads (NumThreads),
    .AddrWidth  (AddrWidth)
  ) u_response (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pc_i             (pc),
    .cur_thread_i     (cur_thread),
    .req_i            (req_o),
    .icache_ready_i   (ready_i),
    .valid_i          (valid_i),
    .data_i           (data_i),
    .fault_i          (fault_i),
    .flush_i          (flush),
    .fetch_ready_i    (fetch_ready_i),
    .vaddr_o          (vaddr_o),
    .can_issue_o      (can_issue),
    .predict_o        (predict),
    .predict_target_o (predict_target),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_instr_o    (fetch_instr_o),
    .fetch_thread_o   (fetch_thread_o),
    .fetch_fault_o    (fetch_fault_o),
    .fetch_taken_o    (fetch_taken_o),
    .fetch_target_o   (fetch_target_o)
  );

endmodule

`default_nettype wire

// ==== design/fetch_response.sv ====
// Fetch response stage
// Drives the fetch address, tags the request in flight, predecodes the
// cache response, applies the kill rules and holds a two-entry buffer
// toward decode with flush removal per thread
`timescale 1ns/1ps
`default_nettype none

module fetch_response #(
  parameter int  NumThreads = 2,
  parameter int  AddrWidth  = fetch_pkg::ADDR_W_DEFAULT,
  localparam int TidW       = (NumThreads > 1) ? $clog2(NumThreads) : 1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [NumThreads-1:0][AddrWidth-1:0] pc_i,
  input  logic [TidW-1:0]                      cur_thread_i,
  input  logic                                 req_i,
  input  logic                                 icache_ready_i,
  input  logic                                 valid_i,
  input  logic [31:0]                          data_i,
  input  logic                                 fault_i,
  input  logic [NumThreads-1:0]                flush_i,
  input  logic                                 fetch_ready_i,
  output logic [AddrWidth-1:0]                 vaddr_o,
  output logic                                 can_issue_o,
  output logic [NumThreads-1:0]                predict_o,
  output logic [AddrWidth-1:0]                 predict_target_o,
  output logic                                 fetch_valid_o,
  output logic [AddrWidth-1:0]                 fetch_pc_o,
  output fetch_pkg::instr_u                    fetch_instr_o,
  output logic [TidW-1:0]                      fetch_thread_o,
  output logic                                 fetch_fault_o,
  output logic                                 fetch_taken_o,
  output logic [AddrWidth-1:0]                 fetch_target_o
);
  import fetch_pkg::*;

  // entry layout from msb: pc, word, thread, fault, taken, target
  localparam int EntryW = 2 * AddrWidth + 32 + TidW + 2;
  localparam int TidLsb = AddrWidth + 2;

  logic                 accept;
  logic                 inflight_q;
  logic                 inflight_kill_q;
  logic [TidW-1:0]      inflight_tid_q;
  logic [AddrWidth-1:0] inflight_pc_q;
  logic                 rsp_keep;
  logic                 scan_taken;
  instr_u               rsp_instr;
  logic [EntryW-1:0]    new_entry;
  logic                 pop;
  logic [1:0]           keep;
  logic [1:0]           buf_valid_q, buf_valid_d;
  logic [1:0][EntryW-1:0] buf_data_q, buf_data_d;

  assign vaddr_o = pc_i[cur_thread_i];
  assign accept  = req_i && icache_ready_i;

  // ----------------------------------------
  // request in flight
  // ----------------------------------------
  // a flush or taken prediction of the thread in the accept cycle kills it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q      <= 1'b0;
      inflight_kill_q <= 1'b0;
    end else begin
      inflight_q      <= accept;
      inflight_kill_q <= flush_i[cur_thread_i] || predict_o[cur_thread_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      inflight_tid_q <= cur_thread_i;
      inflight_pc_q  <= vaddr_o;
    end
  end

  // ----------------------------------------
  // response and predecode
  // ----------------------------------------
  assign rsp_instr = data_i;
  assign rsp_keep  = valid_i && inflight_q && !inflight_kill_q && !flush_i[inflight_tid_q];

  static_branch_scan #(
    .AddrWidth (AddrWidth)
  ) u_scan (
    .pc_i     (inflight_pc_q),
    .instr_i  (rsp_instr),
    .fault_i  (fault_i),
    .taken_o  (scan_taken),
    .target_o (predict_target_o)
  );

  always_comb begin
    predict_o                 = '0;
    predict_o[inflight_tid_q] = rsp_keep && scan_taken;
  end

  assign new_entry = {inflight_pc_q, rsp_instr, inflight_tid_q, fault_i, scan_taken,
                      predict_target_o};

  // ----------------------------------------
  // two-entry output buffer
  // ----------------------------------------
  assign pop     = buf_valid_q[0] && fetch_ready_i;
  assign keep[0] = buf_valid_q[0] && !pop && !flush_i[buf_data_q[0][TidLsb +: TidW]];
  assign keep[1] = buf_valid_q[1] && !flush_i[buf_data_q[1][TidLsb +: TidW]];

  // at most one slot in use once a request is out, so the push always fits
  assign can_issue_o = !(buf_valid_q[1] || (buf_valid_q[0] && inflight_q));

  // survivors move toward the head, the new entry lands behind them
  always_comb begin
    int slot;
    slot        = 0;
    buf_valid_d = '0;
    buf_data_d  = buf_data_q;
    for (int i = 0; i < 2; i++) begin
      if (keep[i]) begin
        buf_valid_d[slot] = 1'b1;
        buf_data_d[slot]  = buf_data_q[i];
        slot++;
      end
    end
    if (rsp_keep) begin
      buf_valid_d[slot] = 1'b1;
      buf_data_d[slot]  = new_entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= '0;
    end else begin
      buf_valid_q <= buf_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_data_q <= buf_data_d;
  end

  assign fetch_valid_o = buf_valid_q[0];
  assign {fetch_pc_o, fetch_instr_o, fetch_thread_o, fetch_fault_o, fetch_taken_o,
          fetch_target_o} = buf_data_q[0];

endmodule

`default_nettype wire

// ==== design/thread_pc.sv ====
// Per-thread program counter
// Starts at the boot address and steps one word per accepted fetch.
// Back-end events and static predictions redirect it by priority
`timescale 1ns/1ps
`default_nettype none

module thread_pc #(
  parameter int  NumThreads = 2,
  parameter int  AddrWidth  = fetch_pkg::ADDR_W_DEFAULT,
  parameter int  ThreadId   = 0,
  localparam int TidW       = (NumThreads > 1) ? $clog2(NumThreads) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] boot_addr_i,
  input  logic                 advance_i,
  input  logic                 predict_i,
  input  logic [AddrWidth-1:0] predict_target_i,
  input  logic                 resolve_valid_i,
  input  logic [TidW-1:0]      resolve_thread_i,
  input  logic [AddrWidth-1:0] resolve_target_i,
  input  logic                 ex_valid_i,
  input  logic                 eret_i,
  input  logic                 set_pc_commit_i,
  input  logic [TidW-1:0]      commit_thread_i,
  input  logic [AddrWidth-1:0] trap_vector_base_i,
  input  logic [AddrWidth-1:0] epc_i,
  input  logic [AddrWidth-1:0] pc_commit_i,
  output logic [AddrWidth-1:0] pc_o,
  output logic                 flush_o
);
  import fetch_pkg::*;

  logic [AddrWidth-1:0] pc_q, pc_d;
  logic                 boot_q;
  logic                 own_commit;
  logic                 mispredict;

  // back-end events that address this thread
  assign own_commit = (commit_thread_i == TidW'(ThreadId));
  assign mispredict = resolve_valid_i && (resolve_thread_i == TidW'(ThreadId));

  assign flush_o = own_commit && (ex_valid_i || eret_i || set_pc_commit_i) || mispredict;

  // boot address is shown until the first edge after reset
  assign pc_o = boot_q ? boot_addr_i : pc_q;

  always_comb begin
    pc_d = pc_o;
    if (own_commit && ex_valid_i) begin
      pc_d = trap_vector_base_i;
    end else if (own_commit && eret_i) begin
      pc_d = epc_i;
    end else if (own_commit && set_pc_commit_i) begin
      pc_d = pc_commit_i + AddrWidth'(INSTR_BYTES);
    end else if (mispredict) begin
      pc_d = resolve_target_i;
    end else if (predict_i) begin
      pc_d = predict_target_i;
    end else if (advance_i) begin
      pc_d = pc_o + AddrWidth'(INSTR_BYTES);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_q <= 1'b1;
    end else begin
      boot_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q <= pc_d;
  end

endmodule

`default_nettype wire

// ==== design/thread_scheduler.sv ====
// Thread scheduler
// Keeps a status per thread, picks the next ready thread in round-robin
// order, raises the cache request and tracks a single outstanding miss
`timescale 1ns/1ps
`default_nettype none

module thread_scheduler #(
  parameter int  NumThreads = 2,
  localparam int TidW       = (NumThreads > 1) ? $clog2(NumThreads) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [NumThreads-1:0] halt_i,
  input  logic                  can_issue_i,
  input  logic                  icache_ready_i,
  output logic                  req_o,
  output logic [TidW-1:0]       cur_thread_o,
  output logic [NumThreads-1:0] advance_o
);
  import fetch_pkg::*;

  thread_status_e [NumThreads-1:0] status_q, status_d;
  logic [NumThreads-1:0] runnable;
  logic [TidW-1:0]       cur_q, cur_d;
  logic [TidW-1:0]       stalled_q, stalled_d;
  logic                  pending_q, pending_d;
  logic                  accept;
  logic                  miss;

  always_comb begin
    for (int i = 0; i < NumThreads; i++) begin
      runnable[i] = (status_q[i] == READY) && !halt_i[i];
    end
  end

  assign req_o        = can_issue_i && runnable[cur_q];
  assign accept       = req_o && icache_ready_i;
  assign miss         = req_o && !icache_ready_i;
  assign cur_thread_o = cur_q;

  always_comb begin
    advance_o        = '0;
    advance_o[cur_q] = accept;
  end

  // ----------------------------------------
  // round-robin choice
  // ----------------------------------------
  // walk from the farthest candidate back so the nearest one wins
  always_comb begin
    int idx;
    cur_d = cur_q;
    for (int k = NumThreads; k >= 1; k--) begin
      idx = (int'(cur_q) + k) % NumThreads;
      if (runnable[idx]) begin
        cur_d = TidW'(idx);
      end
    end
  end

  // ----------------------------------------
  // miss tracking
  // ----------------------------------------
  always_comb begin
    status_d  = status_q;
    pending_d = pending_q;
    stalled_d = stalled_q;
    if (pending_q && icache_ready_i) begin
      // refill done, wake the stalled thread
      status_d[stalled_q] = READY;
      pending_d           = 1'b0;
    end else if (miss && !pending_q) begin
      status_d[cur_q] = STALLED_ICACHE;
      pending_d       = 1'b1;
      stalled_d       = cur_q;
    end
    // a miss while another one is pending is simply retried
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumThreads; i++) begin
        status_q[i] <= READY;
      end
      cur_q     <= '0;
      stalled_q <= '0;
      pending_q <= 1'b0;
    end else begin
      status_q  <= status_d;
      cur_q     <= cur_d;
      stalled_q <= stalled_d;
      pending_q <= pending_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/static_branch_scan.sv ====
// Static branch scan
// Predecodes one fetched word. JAL is always taken, a conditional
// branch is taken when it jumps backward. Faulted words never predict
`timescale 1ns/1ps
`default_nettype none

module static_branch_scan #(
  parameter int AddrWidth = fetch_pkg::ADDR_W_DEFAULT
) (
  input  logic [AddrWidth-1:0] pc_i,
  input  fetch_pkg::instr_u    instr_i,
  input  logic                 fault_i,
  output logic                 taken_o,
  output logic [AddrWidth-1:0] target_o
);
  import fetch_pkg::*;

  logic                 is_jal;
  logic                 is_branch;
  logic [AddrWidth-1:0] jal_imm;
  logic [AddrWidth-1:0] branch_imm;

  assign is_jal    = (instr_i.jal.opcode == OPCODE_JAL);
  assign is_branch = (instr_i.branch.opcode == OPCODE_BRANCH);

  // sign-extended immediates, bit 0 is always zero
  assign jal_imm = {{(AddrWidth - 20){instr_i.jal.imm20}}, instr_i.jal.imm19_12,
                    instr_i.jal.imm11, instr_i.jal.imm10_1, 1'b0};
  assign branch_imm = {{(AddrWidth - 12){instr_i.branch.imm12}}, instr_i.branch.imm11,
                       instr_i.branch.imm10_5, instr_i.branch.imm4_1, 1'b0};

  assign taken_o = !fault_i && (is_jal || (is_branch && branch_imm[AddrWidth-1]));

  // target is the next pc this thread follows
  always_comb begin
    if (taken_o && is_jal) begin
      target_o = pc_i + jal_imm;
    end else if (taken_o) begin
      target_o = pc_i + branch_imm;
    end else begin
      target_o = pc_i + AddrWidth'(INSTR_BYTES);
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// Fetch front end shared definitions
// Thread status, instruction word views and fetch constants used by
// the scheduler, the per-thread counters and the response stage
`default_nettype none

package fetch_pkg;

  // per-thread scheduling state
  typedef enum logic {
    READY          = 1'b0,
    STALLED_ICACHE = 1'b1
  } thread_status_e;

  // ----------------------------------------
  // instruction word views
  // ----------------------------------------
  // J-type layout, imm[20|10:1|11|19:12]
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jal_fmt_t;

  // B-type layout, imm[12|10:5] ... imm[4:1|11]
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } branch_fmt_t;

  // one fetched word, read as raw bits or through either format
  typedef union packed {
    logic [31:0] raw;
    jal_fmt_t    jal;
    branch_fmt_t branch;
  } instr_u;

  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // one word per fetch, no compressed support
  localparam int INSTR_BYTES    = 4;
  localparam int ADDR_W_DEFAULT = 32;

endpackage

`default_nettype wire
